// File: hdl/cce_pkg.sv
////////////////////////////////////////
// Widths, vector types, message enums and
// header structs for the coherence engine.
////////////////////////////////////////

package cce_pkg;

  localparam int PADDR_WIDTH_LP  = 32;
  localparam int LCE_ID_WIDTH_LP = 2;
  localparam int CNT_WIDTH_LP    = 32;

  typedef logic [PADDR_WIDTH_LP-1:0]  paddr_t;
  typedef logic [LCE_ID_WIDTH_LP-1:0] lce_id_t;
  typedef logic [CNT_WIDTH_LP-1:0]    cnt_t;

  // Requests from the LCE.
  typedef enum logic [1:0] {
    e_req_rd_miss = 2'd0,
    e_req_wr_miss = 2'd1,
    e_req_uc_rd   = 2'd2,
    e_req_uc_wr   = 2'd3
  } req_type_e;

  typedef enum logic [1:0] {
    e_cmd_data    = 2'd0, // Cached fill.
    e_cmd_uc_data = 2'd1, // Uncached read return.
    e_cmd_uc_done = 2'd2  // Uncached write completion.
  } lce_cmd_type_e;

  typedef enum logic [0:0] {
    e_resp_coh_ack = 1'b0
  } lce_resp_type_e;

  typedef enum logic [0:0] {
    e_mem_rd = 1'b0,
    e_mem_wr = 1'b1
  } mem_op_e;

  typedef struct packed {
    req_type_e msg_type;
    paddr_t    addr;
    lce_id_t   lce_id;
  } lce_req_hdr_s;

  typedef struct packed {
    lce_cmd_type_e msg_type;
    paddr_t        addr;
    lce_id_t       lce_id;
  } lce_cmd_hdr_s;

  typedef struct packed {
    lce_resp_type_e msg_type;
    paddr_t         addr;
    lce_id_t        lce_id;
  } lce_resp_hdr_s;

  // Memory commands and responses share this layout.
  typedef struct packed {
    mem_op_e opcode;
    paddr_t  addr;
    lce_id_t lce_id;
  } mem_hdr_s;

endpackage

// File: hdl/cce_counter.sv
////////////////////////////////////////
// Saturating counter with clear and up.
////////////////////////////////////////

`timescale 1ns/1ps

module cce_counter
  import cce_pkg::*;
(
  input  logic clk_i,
  input  logic reset_i,
  input  logic clear_i,
  input  logic up_i,
  output cnt_t count_o
);

  cnt_t count_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_r <= '0;
    end else if (clear_i) begin
      count_r <= '0; // Clear wins over up.
    end else if (up_i && (count_r != '1)) begin
      count_r <= count_r + 1'b1; // Holds at the maximum.
    end
  end

  assign count_o = count_r;

endmodule

// File: hdl/cce_req_engine.sv
////////////////////////////////////////
// Request engine serving one LCE request
// through memory and back to the LCE.
////////////////////////////////////////

`timescale 1ns/1ps

module cce_req_engine
  import cce_pkg::*;
(
  input  logic          clk_i,
  input  logic          reset_i,

  input  logic          lce_req_v_i,
  input  lce_req_hdr_s  lce_req_hdr_i,
  output logic          lce_req_ready_o,

  output logic          mem_cmd_v_o,
  output mem_hdr_s      mem_cmd_hdr_o,

  input  logic          mem_resp_v_i,
  input  mem_hdr_s      mem_resp_hdr_i,

  output logic          lce_cmd_v_o,
  output lce_cmd_hdr_s  lce_cmd_hdr_o,

  input  logic          lce_resp_v_i,
  input  lce_resp_hdr_s lce_resp_hdr_i,

  output logic          req_start_o,
  output logic          req_end_o,
  output lce_req_hdr_s  req_hdr_o
);

  typedef enum logic [2:0] {
    e_ready,
    e_mem_cmd,
    e_mem_wait,
    e_lce_cmd,
    e_ack_wait
  } state_e;

  state_e       state_r;
  state_e       state_n;
  lce_req_hdr_s req_r;
  logic         accept;
  logic         ack_done;
  logic         needs_ack;
  mem_op_e      mem_op;
  lce_cmd_type_e cmd_type;

  assign accept    = lce_req_v_i & lce_req_ready_o;
  assign needs_ack = (req_r.msg_type == e_req_wr_miss);
  assign ack_done  = (state_r == e_ack_wait) & lce_resp_v_i
                   & (lce_resp_hdr_i.msg_type == e_resp_coh_ack);

  always_comb begin
    state_n = state_r;
    case (state_r)
      e_ready:    if (accept) state_n = e_mem_cmd;
      e_mem_cmd:  state_n = e_mem_wait;
      e_mem_wait: if (mem_resp_v_i) state_n = e_lce_cmd;
      e_lce_cmd:  state_n = needs_ack ? e_ack_wait : e_ready;
      e_ack_wait: if (ack_done) state_n = e_ready;
      default:    state_n = e_ready;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= e_ready;
    end else begin
      state_r <= state_n;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_r <= lce_req_hdr_i;
    end
  end

  // Only an uncached write stores to memory.
  always_comb begin
    case (req_r.msg_type)
      e_req_uc_wr: mem_op = e_mem_wr;
      default:     mem_op = e_mem_rd;
    endcase
  end

  always_comb begin
    case (req_r.msg_type)
      e_req_uc_rd: cmd_type = e_cmd_uc_data;
      e_req_uc_wr: cmd_type = e_cmd_uc_done;
      default:     cmd_type = e_cmd_data;
    endcase
  end

  assign lce_req_ready_o = (state_r == e_ready);

  assign mem_cmd_v_o          = (state_r == e_mem_cmd);
  assign mem_cmd_hdr_o.opcode = mem_op;
  assign mem_cmd_hdr_o.addr   = req_r.addr;
  assign mem_cmd_hdr_o.lce_id = req_r.lce_id;

  assign lce_cmd_v_o            = (state_r == e_lce_cmd);
  assign lce_cmd_hdr_o.msg_type = cmd_type;
  assign lce_cmd_hdr_o.addr     = req_r.addr;
  assign lce_cmd_hdr_o.lce_id   = req_r.lce_id;

  assign req_start_o = accept;
  assign req_end_o   = ((state_r == e_lce_cmd) & ~needs_ack) | ack_done;
  assign req_hdr_o   = lce_req_ready_o ? lce_req_hdr_i : req_r; // Accepted header at start.

  // The outside holds new requests while the engine is busy.
  req_only_when_ready_a: assert property (
    @(posedge clk_i) disable iff (reset_i)
    lce_req_v_i |-> lce_req_ready_o
  );

  mem_resp_matches_a: assert property (
    @(posedge clk_i) disable iff (reset_i)
    mem_resp_v_i |-> (state_r == e_mem_wait) && (mem_resp_hdr_i.addr == req_r.addr)
  );

  lce_resp_matches_a: assert property (
    @(posedge clk_i) disable iff (reset_i)
    lce_resp_v_i |-> (state_r == e_ack_wait) && (lce_resp_hdr_i.lce_id == req_r.lce_id)
  );

endmodule

// File: hdl/cce_perf_monitor.sv
////////////////////////////////////////
// Latency, cycle and request statistics
// taken from the engine's strobes.
////////////////////////////////////////

`timescale 1ns/1ps

module cce_perf_monitor
  import cce_pkg::*;
(
  input  logic         clk_i,
  input  logic         reset_i,
  input  logic         req_start_i,
  input  logic         req_end_i,
  input  lce_req_hdr_s req_hdr_i,
  output logic         stat_v_o,
  output cnt_t         last_latency_o,
  output cnt_t         total_cycles_o,
  output cnt_t         idle_cycles_o,
  output cnt_t         req_count_o,
  output req_type_e    last_op_o
);

  logic         open_r;
  lce_req_hdr_s hdr_r;
  cnt_t         lat_cnt;
  cnt_t         req_count_r;

  cce_counter i_latency_counter (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .clear_i (req_start_i),
    .up_i    (open_r),
    .count_o (lat_cnt)
  );

  cce_counter i_total_counter (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .clear_i (1'b0),
    .up_i    (1'b1),
    .count_o (total_cycles_o)
  );

  // The accept cycle still counts as idle.
  cce_counter i_idle_counter (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .clear_i (1'b0),
    .up_i    (~open_r),
    .count_o (idle_cycles_o)
  );

  always_ff @(posedge clk_i) begin
    if (req_start_i) begin
      hdr_r <= req_hdr_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      open_r         <= 1'b0;
      stat_v_o       <= 1'b0;
      last_latency_o <= '0;
      last_op_o      <= e_req_rd_miss;
      req_count_r    <= '0;
    end else begin
      stat_v_o <= req_end_i & open_r;
      if (req_start_i) begin
        open_r <= 1'b1;
      end else if (req_end_i) begin
        open_r <= 1'b0;
      end
      if (req_end_i & open_r) begin
        // The counter lags the end cycle by one.
        last_latency_o <= (lat_cnt == '1) ? lat_cnt : cnt_t'(lat_cnt + 1'b1);
        last_op_o      <= hdr_r.msg_type;
        if (req_count_r != '1) begin
          req_count_r <= req_count_r + 1'b1;
        end
      end
    end
  end

  assign req_count_o = req_count_r;

  end_needs_open_a: assert property (
    @(posedge clk_i) disable iff (reset_i)
    req_end_i |-> open_r
  );

endmodule

// File: hdl/cce_top.sv
////////////////////////////////////////
// Top level with the request engine and
// its performance monitor.
////////////////////////////////////////

`timescale 1ns/1ps

module cce_top
  import cce_pkg::*;
(
  input  logic          clk_i,
  input  logic          reset_i,

  input  logic          lce_req_v_i,
  input  lce_req_hdr_s  lce_req_hdr_i,
  output logic          lce_req_ready_o,

  output logic          mem_cmd_v_o,
  output mem_hdr_s      mem_cmd_hdr_o,

  input  logic          mem_resp_v_i,
  input  mem_hdr_s      mem_resp_hdr_i,

  output logic          lce_cmd_v_o,
  output lce_cmd_hdr_s  lce_cmd_hdr_o,

  input  logic          lce_resp_v_i,
  input  lce_resp_hdr_s lce_resp_hdr_i,

  output logic          stat_v_o,
  output cnt_t          last_latency_o,
  output cnt_t          total_cycles_o,
  output cnt_t          idle_cycles_o,
  output cnt_t          req_count_o,
  output req_type_e     last_op_o
);

  logic         req_start;
  logic         req_end;
  lce_req_hdr_s req_hdr;

  cce_req_engine i_engine (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .lce_req_v_i     (lce_req_v_i),
    .lce_req_hdr_i   (lce_req_hdr_i),
    .lce_req_ready_o (lce_req_ready_o),
    .mem_cmd_v_o     (mem_cmd_v_o),
    .mem_cmd_hdr_o   (mem_cmd_hdr_o),
    .mem_resp_v_i    (mem_resp_v_i),
    .mem_resp_hdr_i  (mem_resp_hdr_i),
    .lce_cmd_v_o     (lce_cmd_v_o),
    .lce_cmd_hdr_o   (lce_cmd_hdr_o),
    .lce_resp_v_i    (lce_resp_v_i),
    .lce_resp_hdr_i  (lce_resp_hdr_i),
    .req_start_o     (req_start),
    .req_end_o       (req_end),
    .req_hdr_o       (req_hdr)
  );

  cce_perf_monitor i_monitor (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .req_start_i    (req_start),
    .req_end_i      (req_end),
    .req_hdr_i      (req_hdr),
    .stat_v_o       (stat_v_o),
    .last_latency_o (last_latency_o),
    .total_cycles_o (total_cycles_o),
    .idle_cycles_o  (idle_cycles_o),
    .req_count_o    (req_count_o),
    .last_op_o      (last_op_o)
  );

endmodule

// File: testbench/tb_cce_ref.svh
////////////////////////////////////////
// Expected opcodes, command types, ack
// rule, latency and cycle accounting.
////////////////////////////////////////

`ifndef TB_CCE_REF_SVH
`define TB_CCE_REF_SVH

// Only an uncached write goes to memory as a store.
function automatic mem_op_e expected_mem_op(input req_type_e req_type);
  if (req_type == e_req_uc_wr) begin
    return e_mem_wr;
  end
  return e_mem_rd;
endfunction

function automatic lce_cmd_type_e expected_cmd_type(input req_type_e req_type);
  case (req_type)
    e_req_uc_rd: return e_cmd_uc_data;
    e_req_uc_wr: return e_cmd_uc_done;
    default:     return e_cmd_data; // Both miss types get a fill.
  endcase
endfunction

// A write miss finishes only with the LCE acknowledgement.
function automatic bit needs_ack(input req_type_e req_type);
  return (req_type == e_req_wr_miss);
endfunction

function automatic longint expected_latency(input longint t_accept, input longint t_end);
  return t_end - t_accept;
endfunction

// Every cycle is either idle or part of one request's latency.
function automatic longint expected_idle(input longint total, input longint latency_sum);
  return total - latency_sum;
endfunction

`endif

// File: testbench/tb_cce_top.sv
////////////////////////////////////////
// Testbench for cce_top with LCE and
// memory models, checker and watchdog.
////////////////////////////////////////

`timescale 1ns/1ps

module tb_cce_top
  import cce_pkg::*;
;

  localparam int CLK_PERIOD_NS   = 10;
  localparam int RESET_CYCLES    = 10;
  localparam int NUM_REQ         = 200;
  localparam int WATCHDOG_CYCLES = NUM_REQ * 40 + RESET_CYCLES + 20;

  `include "tb_cce_ref.svh"

  logic          clk_i;
  logic          reset_i;
  logic          lce_req_v_i;
  lce_req_hdr_s  lce_req_hdr_i;
  logic          lce_req_ready_o;
  logic          mem_cmd_v_o;
  mem_hdr_s      mem_cmd_hdr_o;
  logic          mem_resp_v_i;
  mem_hdr_s      mem_resp_hdr_i;
  logic          lce_cmd_v_o;
  lce_cmd_hdr_s  lce_cmd_hdr_o;
  logic          lce_resp_v_i;
  lce_resp_hdr_s lce_resp_hdr_i;
  logic          stat_v_o;
  cnt_t          last_latency_o;
  cnt_t          total_cycles_o;
  cnt_t          idle_cycles_o;
  cnt_t          req_count_o;
  req_type_e     last_op_o;

  longint       cyc = 0;           // Cycles since reset, counted at each rising edge.
  longint       t_accept = -1;
  longint       end_cyc = -1;
  longint       exp_mem_cyc = -1;
  longint       exp_cmd_cyc = -1;
  longint       exp_stat_cyc = -1;
  longint       exp_latency = 0;
  longint       latency_sum = 0;
  longint       done_count = 0;
  bit           busy = 1'b0;
  lce_req_hdr_s cur_hdr = '0;
  req_type_e    cur_type = e_req_rd_miss; // Type of the request in flight, for the LCE model.

  cce_top i_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD_NS / 2) clk_i = ~clk_i;
  end

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("[FAIL] time=%0t signal=%s got=0x%0h expected=0x%0h", $time, name, got, exp);
      $display("sim failed");
      $fatal(1, "Mismatch on %s.", name);
    end
  endtask

  task automatic finish_request(input longint t_end);
    end_cyc      = t_end;
    exp_stat_cyc = t_end + 1;
    exp_latency  = expected_latency(t_accept, t_end);
    latency_sum  = latency_sum + exp_latency;
    done_count   = done_count + 1;
  endtask

  initial begin : stimulus
    int gap;
    lce_req_hdr_s hdr;
    void'($urandom(32'h5e0a));
    reset_i       = 1'b1;
    lce_req_v_i   = 1'b0;
    lce_req_hdr_i = '0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    for (int n = 0; n < NUM_REQ; n++) begin
      while (!lce_req_ready_o) @(negedge clk_i);
      gap = $urandom_range(3, 0);
      repeat (gap) @(negedge clk_i);
      hdr.msg_type  = req_type_e'($urandom_range(3, 0));
      hdr.addr      = $urandom();
      hdr.lce_id    = lce_id_t'($urandom_range(3, 0));
      cur_type      = hdr.msg_type;
      lce_req_hdr_i = hdr;
      lce_req_v_i   = 1'b1;
      @(negedge clk_i);
      lce_req_v_i = 1'b0;
    end
    while (!lce_req_ready_o) @(negedge clk_i);
    repeat (3) @(negedge clk_i);
    check_value("req_count_o", req_count_o, NUM_REQ);
    check_value("total_cycles_o", total_cycles_o, cyc);
    check_value("idle_cycles_o", idle_cycles_o, expected_idle(cyc, latency_sum));
    $display("sim passed");
    $finish;
  end

  // Memory answers each command after 1 to 8 cycles.
  initial begin : memory_model
    mem_hdr_s cmd;
    int delay;
    mem_resp_v_i   = 1'b0;
    mem_resp_hdr_i = '0;
    forever begin
      @(posedge clk_i);
      if (!reset_i && mem_cmd_v_o) begin
        cmd   = mem_cmd_hdr_o;
        delay = $urandom_range(8, 1);
        repeat (delay) @(negedge clk_i);
        mem_resp_hdr_i = cmd;
        mem_resp_v_i   = 1'b1;
        @(negedge clk_i);
        mem_resp_v_i = 1'b0;
      end
    end
  end

  initial begin : lce_model
    int delay;
    lce_resp_v_i   = 1'b0;
    lce_resp_hdr_i = '0;
    forever begin
      @(posedge clk_i);
      if (!reset_i && lce_cmd_v_o && needs_ack(cur_type)) begin
        delay = $urandom_range(5, 0);
        repeat (delay + 1) @(negedge clk_i);
        lce_resp_hdr_i.msg_type = e_resp_coh_ack;
        lce_resp_hdr_i.addr     = lce_cmd_hdr_o.addr;
        lce_resp_hdr_i.lce_id   = lce_cmd_hdr_o.lce_id;
        lce_resp_v_i            = 1'b1;
        @(negedge clk_i);
        lce_resp_v_i = 1'b0;
      end
    end
  end

  always @(posedge clk_i) begin : compare
    if (!reset_i) begin
      if (cyc == 0) begin
        check_value("last_latency_o", last_latency_o, 0);
        check_value("total_cycles_o", total_cycles_o, 0);
        check_value("idle_cycles_o", idle_cycles_o, 0);
        check_value("req_count_o", req_count_o, 0);
      end
      check_value("lce_req_ready_o", lce_req_ready_o, !busy);
      check_value("mem_cmd_v_o", mem_cmd_v_o, cyc == exp_mem_cyc);
      if (mem_cmd_v_o) begin
        check_value("mem_cmd_hdr_o.opcode", mem_cmd_hdr_o.opcode,
                    expected_mem_op(cur_hdr.msg_type));
        check_value("mem_cmd_hdr_o.addr", mem_cmd_hdr_o.addr, cur_hdr.addr);
        check_value("mem_cmd_hdr_o.lce_id", mem_cmd_hdr_o.lce_id, cur_hdr.lce_id);
      end
      check_value("lce_cmd_v_o", lce_cmd_v_o, cyc == exp_cmd_cyc);
      if (lce_cmd_v_o) begin
        check_value("lce_cmd_hdr_o.msg_type", lce_cmd_hdr_o.msg_type,
                    expected_cmd_type(cur_hdr.msg_type));
        check_value("lce_cmd_hdr_o.addr", lce_cmd_hdr_o.addr, cur_hdr.addr);
        check_value("lce_cmd_hdr_o.lce_id", lce_cmd_hdr_o.lce_id, cur_hdr.lce_id);
      end
      check_value("stat_v_o", stat_v_o, cyc == exp_stat_cyc);
      if (stat_v_o) begin
        check_value("last_op_o", last_op_o, cur_hdr.msg_type);
        check_value("last_latency_o", last_latency_o, exp_latency);
        check_value("req_count_o", req_count_o, done_count);
      end
      if (lce_req_v_i) begin
        cur_hdr     = lce_req_hdr_i;
        t_accept    = cyc;
        busy        = 1'b1;
        exp_mem_cyc = cyc + 1;
      end
      if (mem_resp_v_i) begin
        exp_cmd_cyc = cyc + 1;
        if (!needs_ack(cur_hdr.msg_type)) begin
          finish_request(cyc + 1); // Done with the LCE command.
        end
      end
      if (lce_resp_v_i) begin
        finish_request(cyc);
      end
      if (busy && cyc == end_cyc) begin
        busy = 1'b0;
      end
      cyc = cyc + 1;
    end
  end

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
    $display("Timeout: the requests did not finish within %0d cycles.", WATCHDOG_CYCLES);
    $display("sim failed");
    $fatal(1, "Watchdog expired.");
  end

endmodule

// File: build.f
+incdir+testbench
hdl/cce_pkg.sv
hdl/cce_counter.sv
hdl/cce_req_engine.sv
hdl/cce_perf_monitor.sv
hdl/cce_top.sv
testbench/tb_cce_top.sv

// File: Makefile
# Verilator build and run of the coherence engine testbench.
TOP := tb_cce_top

sim:
	rm -f sim.log
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP) -Mdir obj_dir
	-./obj_dir/V$(TOP) | tee sim.log
	grep -q "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
